//--- design/cpu_pkg.sv
package cpu_pkg;

	localparam int XLEN = 32;
	localparam int REG_COUNT = 32;
	localparam int REG_BITS = 5;
	localparam int IMEM_DEPTH = 256;
	localparam int DMEM_DEPTH = 256;
	localparam int IMEM_ADDR_BITS = 8;
	localparam int DMEM_ADDR_BITS = 8;

	////////////////////
	// Instruction fields
	localparam int OPC_HI = 31;
	localparam int OPC_LO = 27;
	localparam int RD_HI = 26;
	localparam int RD_LO = 22;
	localparam int RS_HI = 21;
	localparam int RS_LO = 17;
	localparam int RT_HI = 16;
	localparam int RT_LO = 12;
	// Immediate overlaps rt, so SW and branches take their second source from rd
	localparam int IMM_HI = 16;
	localparam int IMM_LO = 0;
	localparam int IMM_BITS = IMM_HI - IMM_LO + 1;

	// Branch condition select
	localparam logic [1:0] CMP_NONE = 2'd0;
	localparam logic [1:0] CMP_EQ = 2'd1;
	localparam logic [1:0] CMP_NE = 2'd2;
	localparam logic [1:0] CMP_LT = 2'd3;

	////////////////////
	typedef enum logic [4:0] {
		OP_NOP = 5'd0,
		OP_ADD = 5'd1,
		OP_SUB = 5'd2,
		OP_AND = 5'd3,
		OP_OR = 5'd4,
		OP_XOR = 5'd5,
		OP_SLL = 5'd6,
		OP_SRL = 5'd7,
		OP_ADDI = 5'd8,
		OP_LW = 5'd9,
		OP_SW = 5'd10,
		OP_BEQ = 5'd11,
		OP_BNE = 5'd12,
		OP_BLT = 5'd13,
		OP_JMP = 5'd14,
		OP_HALT = 5'd15
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL
	} alu_op_e;

	typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwd_sel_e;

	typedef enum logic [1:0] {ST_LOAD, ST_RUN, ST_HALT} cpu_state_e;

	////////////////////
	typedef struct packed {
		logic [IMEM_ADDR_BITS-1:0] addr;
		logic [XLEN-1:0]           data;
	} load_word_t;

	typedef struct packed {
		alu_op_e    alu_op;
		logic       use_imm;
		logic       reg_write;
		logic       mem_read;
		logic       mem_write;
		logic       branch;
		logic       jump;
		logic       halt;
		logic [1:0] cmp_kind;
	} ctrl_t;

	typedef struct packed {
		logic                      valid;
		logic [IMEM_ADDR_BITS-1:0] pc;
		logic [XLEN-1:0]           instr;
	} if_id_t;

	typedef struct packed {
		logic                      valid;
		ctrl_t                     ctrl;
		logic [IMEM_ADDR_BITS-1:0] pc;
		logic [REG_BITS-1:0]       rd;
		logic [REG_BITS-1:0]       rs;
		logic [REG_BITS-1:0]       rt;
		logic [XLEN-1:0]           rs_data;
		logic [XLEN-1:0]           rt_data;
		logic [XLEN-1:0]           imm;
	} id_ex_t;

	typedef struct packed {
		logic                valid;
		ctrl_t               ctrl;
		logic [REG_BITS-1:0] rd;
		logic [XLEN-1:0]     result;
		logic [XLEN-1:0]     store_data;
	} ex_mem_t;

	typedef struct packed {
		logic                valid;
		ctrl_t               ctrl;
		logic [REG_BITS-1:0] rd;
		logic [XLEN-1:0]     alu_result;
		logic [XLEN-1:0]     load_data;
	} mem_wb_t;

	typedef struct packed {
		logic [REG_BITS-1:0] rd;
		logic [XLEN-1:0]     data;
	} wb_event_t;

endpackage

//--- design/instr_mem.sv
module instr_mem (
	input  logic                                clock,
	input  logic                                rst_n,
	input  logic                                load_enable,
	input  logic                                load_req,
	input  cpu_pkg::load_word_t                 load_word,
	output logic                                load_ack,
	input  logic                                fetch_enable,
	input  logic [cpu_pkg::IMEM_ADDR_BITS-1:0]  fetch_addr,
	output logic [cpu_pkg::XLEN-1:0]            instr
);
	import cpu_pkg::*;

	logic [XLEN-1:0] mem [IMEM_DEPTH];
	logic load_write;

	// One write per handshake on the first clock that sees req without ack
	assign load_write = load_enable & load_req & ~load_ack;

	////////////////////
	// Host load port
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			load_ack <= 1'b0;
		end else if (load_write) begin
			load_ack <= 1'b1;
		end else if (!load_req) begin
			load_ack <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (load_write) begin
			mem[load_word.addr] <= load_word.data;
		end
	end

	////////////////////
	// Fetch read holds its output during a stall
	always_ff @(posedge clock) begin
		if (fetch_enable) begin
			instr <= mem[fetch_addr];
		end
	end

endmodule

//--- design/reg_file.sv
module reg_file (
	input  logic                          clock,
	input  logic                          rst_n,
	input  logic [cpu_pkg::REG_BITS-1:0]  read_a,
	input  logic [cpu_pkg::REG_BITS-1:0]  read_b,
	output logic [cpu_pkg::XLEN-1:0]      data_a,
	output logic [cpu_pkg::XLEN-1:0]      data_b,
	input  logic                          write_en,
	input  logic [cpu_pkg::REG_BITS-1:0]  write_reg,
	input  logic [cpu_pkg::XLEN-1:0]      write_data
);
	import cpu_pkg::*;

	logic [XLEN-1:0] regs [REG_COUNT];

	// r0 reads zero and a same-cycle write passes straight through
	function automatic logic [XLEN-1:0] read_port(input logic [REG_BITS-1:0] sel);
		if (sel == '0) begin
			return '0;
		end
		if (write_en && write_reg == sel) begin
			return write_data;
		end
		return regs[sel];
	endfunction

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en && write_reg != '0) begin
			regs[write_reg] <= write_data;
		end
	end

	always_comb begin
		data_a = read_port(read_a);
		data_b = read_port(read_b);
	end

endmodule

//--- design/alu.sv
module alu (
	input  cpu_pkg::alu_op_e           op,
	input  logic [1:0]                 cmp_kind,
	input  logic [cpu_pkg::XLEN-1:0]   a,
	input  logic [cpu_pkg::XLEN-1:0]   b,
	output logic [cpu_pkg::XLEN-1:0]   result,
	output logic                       take_branch
);
	import cpu_pkg::*;

	logic equal;
	logic less;

	always_comb begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_XOR: result = a ^ b;
			// Shift amount from the low five bits
			ALU_SLL: result = a << b[4:0];
			ALU_SRL: result = a >> b[4:0];
			default: result = a + b;
		endcase
	end

	////////////////////
	// Branch compare in execute
	assign equal = (a == b);
	assign less = ($signed(a) < $signed(b));

	always_comb begin
		case (cmp_kind)
			CMP_EQ:  take_branch = equal;
			CMP_NE:  take_branch = ~equal;
			CMP_LT:  take_branch = less;
			default: take_branch = 1'b0;
		endcase
	end

endmodule

//--- design/data_mem.sv
module data_mem (
	input  logic                                clock,
	input  logic [cpu_pkg::DMEM_ADDR_BITS-1:0]  addr,
	input  logic                                write_en,
	input  logic [cpu_pkg::XLEN-1:0]            write_data,
	output logic [cpu_pkg::XLEN-1:0]            read_data
);
	import cpu_pkg::*;

	logic [XLEN-1:0] mem [DMEM_DEPTH];

	// Address comes from the memory stage latch,
	// so the read lands alongside the writeback latch
	always_ff @(posedge clock) begin
		if (write_en) begin
			mem[addr] <= write_data;
		end
		read_data <= mem[addr];
	end

endmodule

//--- design/pipeline_control.sv
module pipeline_control (
	input  logic                          clock,
	input  logic                          rst_n,
	input  logic                          run,
	input  cpu_pkg::if_id_t               ifid,
	input  cpu_pkg::id_ex_t               idex,
	input  logic [cpu_pkg::REG_BITS-1:0]  mem_rd,
	input  logic                          mem_write_reg,
	input  logic [cpu_pkg::REG_BITS-1:0]  wb_rd,
	input  logic                          wb_write_reg,
	input  logic                          wb_halt,
	input  logic                          take_branch,
	output logic                          load_enable,
	output logic                          fetch_enable,
	output cpu_pkg::ctrl_t                ctrl,
	output logic                          stall,
	output logic                          flush,
	output cpu_pkg::fwd_sel_e             fwd_a,
	output cpu_pkg::fwd_sel_e             fwd_b,
	output logic                          halted
);
	import cpu_pkg::*;

	cpu_state_e state;
	logic halt_seen;
	opcode_e opcode;
	ctrl_t dec;
	logic [REG_BITS-1:0] dec_rs, dec_src_b;
	logic uses_a, uses_b, load_use, ex_redirect, dec_halt;

	// Memory stage wins over writeback
	function automatic fwd_sel_e pick_source(input logic [REG_BITS-1:0] src,
			input logic [REG_BITS-1:0] m_rd, input logic m_wr,
			input logic [REG_BITS-1:0] w_rd, input logic w_wr);
		if (m_wr && m_rd != '0 && m_rd == src) begin
			return FWD_MEM;
		end
		if (w_wr && w_rd != '0 && w_rd == src) begin
			return FWD_WB;
		end
		return FWD_REG;
	endfunction

	////////////////////
	// Decode
	assign opcode = opcode_e'(ifid.instr[OPC_HI:OPC_LO]);

	always_comb begin
		dec = '0;
		dec.cmp_kind = CMP_NONE;
		case (opcode)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL: begin
				dec.reg_write = 1'b1;
			end
			OP_ADDI: begin
				dec.use_imm = 1'b1;
				dec.reg_write = 1'b1;
			end
			OP_LW: begin
				dec.use_imm = 1'b1;
				dec.reg_write = 1'b1;
				dec.mem_read = 1'b1;
			end
			OP_SW: begin
				dec.use_imm = 1'b1;
				dec.mem_write = 1'b1;
			end
			OP_BEQ: begin
				dec.branch = 1'b1;
				dec.cmp_kind = CMP_EQ;
			end
			OP_BNE: begin
				dec.branch = 1'b1;
				dec.cmp_kind = CMP_NE;
			end
			OP_BLT: begin
				dec.branch = 1'b1;
				dec.cmp_kind = CMP_LT;
			end
			OP_JMP:  dec.jump = 1'b1;
			OP_HALT: dec.halt = 1'b1;
			// NOP and unused encodings stay a bubble
			default: dec = '0;
		endcase
		case (opcode)
			OP_SUB:  dec.alu_op = ALU_SUB;
			OP_AND:  dec.alu_op = ALU_AND;
			OP_OR:   dec.alu_op = ALU_OR;
			OP_XOR:  dec.alu_op = ALU_XOR;
			OP_SLL:  dec.alu_op = ALU_SLL;
			OP_SRL:  dec.alu_op = ALU_SRL;
			default: dec.alu_op = ALU_ADD;
		endcase
	end

	// Second source is rd for stores and branches
	assign dec_rs = ifid.instr[RS_HI:RS_LO];
	assign dec_src_b = (dec.mem_write | dec.branch) ? ifid.instr[RD_HI:RD_LO]
		: ifid.instr[RT_HI:RT_LO];
	assign uses_a = dec.reg_write | dec.mem_write | dec.branch;
	assign uses_b = (dec.reg_write & ~dec.use_imm) | dec.mem_write | dec.branch;

	////////////////////
	// Hazards
	assign load_use = ifid.valid & idex.valid & idex.ctrl.mem_read & (idex.rd != '0)
		& ((uses_a & (idex.rd == dec_rs)) | (uses_b & (idex.rd == dec_src_b)));
	assign ex_redirect = idex.valid & ((idex.ctrl.branch & take_branch) | idex.ctrl.jump);
	// A HALT on the wrong path does not count
	assign dec_halt = ifid.valid & dec.halt & ~ex_redirect;

	assign stall = load_use;
	assign flush = ex_redirect | dec_halt;
	assign ctrl = (ifid.valid & ~load_use & ~ex_redirect) ? dec : '0;

	assign fwd_a = pick_source(idex.rs, mem_rd, mem_write_reg, wb_rd, wb_write_reg);
	assign fwd_b = pick_source(idex.rt, mem_rd, mem_write_reg, wb_rd, wb_write_reg);

	////////////////////
	// Run state
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state <= ST_LOAD;
			halt_seen <= 1'b0;
		end else begin
			case (state)
				ST_LOAD: if (run) state <= ST_RUN;
				ST_RUN:  if (wb_halt) state <= ST_HALT;
				ST_HALT: state <= ST_HALT;
				default: state <= ST_LOAD;
			endcase
			if (dec_halt) begin
				halt_seen <= 1'b1;
			end
		end
	end

	assign load_enable = (state == ST_LOAD);
	// Nothing past a HALT is fetched
	assign fetch_enable = (state == ST_RUN) & ~halt_seen & ~load_use;
	assign halted = (state == ST_HALT);

endmodule

//--- design/pipe_cpu.sv
module pipe_cpu (
	input  logic                  clock,
	input  logic                  rst_n,
	input  logic                  load_req,
	input  cpu_pkg::load_word_t   load_word,
	output logic                  load_ack,
	input  logic                  run,
	output logic                  wb_valid,
	output cpu_pkg::wb_event_t    wb_event,
	output logic                  halted
);
	import cpu_pkg::*;

	logic [IMEM_ADDR_BITS-1:0] pc_q, pc_next, ifid_pc_q;
	logic ifid_valid_q;
	logic [XLEN-1:0] imem_instr;
	if_id_t ifid;
	id_ex_t idex_q;
	ex_mem_t exmem_q;
	logic memwb_valid_q;
	ctrl_t memwb_ctrl_q;
	logic [REG_BITS-1:0] memwb_rd_q;
	logic [XLEN-1:0] memwb_alu_q, dmem_rdata;
	mem_wb_t memwb;

	ctrl_t ctrl_dec;
	logic stall, flush, fetch_enable, load_enable;
	fwd_sel_e fwd_a, fwd_b;
	logic [REG_BITS-1:0] read_b;
	logic [XLEN-1:0] rf_a, rf_b, imm_dec;
	logic [XLEN-1:0] op_a, op_b, alu_b, alu_result, wb_data;
	logic take_branch, branch_taken, redirect, rf_write;

	function automatic logic [XLEN-1:0] fwd_mux(input fwd_sel_e sel,
			input logic [XLEN-1:0] reg_val, input logic [XLEN-1:0] mem_val,
			input logic [XLEN-1:0] wb_val);
		case (sel)
			FWD_MEM: return mem_val;
			FWD_WB:  return wb_val;
			default: return reg_val;
		endcase
	endfunction

	pipeline_control control (.clock(clock), .rst_n(rst_n), .run(run), .ifid(ifid),
		.idex(idex_q), .mem_rd(exmem_q.rd), .mem_write_reg(exmem_q.valid & exmem_q.ctrl.reg_write),
		.wb_rd(memwb.rd), .wb_write_reg(rf_write), .wb_halt(memwb.valid & memwb.ctrl.halt),
		.take_branch(take_branch), .load_enable(load_enable), .fetch_enable(fetch_enable),
		.ctrl(ctrl_dec), .stall(stall), .flush(flush), .fwd_a(fwd_a), .fwd_b(fwd_b),
		.halted(halted));

	////////////////////
	// Fetch
	instr_mem imem (.clock(clock), .rst_n(rst_n), .load_enable(load_enable),
		.load_req(load_req), .load_word(load_word), .load_ack(load_ack),
		.fetch_enable(fetch_enable), .fetch_addr(pc_q), .instr(imem_instr));

	// Jump is absolute, branch is relative to pc+1
	assign pc_next = idex_q.ctrl.jump ? idex_q.imm[IMEM_ADDR_BITS-1:0]
		: branch_taken ? idex_q.pc + 1'b1 + idex_q.imm[IMEM_ADDR_BITS-1:0]
		: pc_q + 1'b1;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			pc_q <= '0;
			ifid_valid_q <= 1'b0;
		end else begin
			if (redirect || fetch_enable) begin
				pc_q <= pc_next;
			end
			if (flush) begin
				ifid_valid_q <= 1'b0;
			end else if (fetch_enable) begin
				ifid_valid_q <= 1'b1;
			end
		end
		if (fetch_enable) begin
			ifid_pc_q <= pc_q;
		end
	end

	// Memory output is the instruction half of the fetch latch
	assign ifid = '{valid: ifid_valid_q, pc: ifid_pc_q, instr: imem_instr};

	////////////////////
	// Decode
	assign read_b = (ctrl_dec.mem_write | ctrl_dec.branch) ? ifid.instr[RD_HI:RD_LO]
		: ifid.instr[RT_HI:RT_LO];
	assign imm_dec = {{(XLEN - IMM_BITS){ifid.instr[IMM_HI]}}, ifid.instr[IMM_HI:IMM_LO]};

	reg_file rf (.clock(clock), .rst_n(rst_n), .read_a(ifid.instr[RS_HI:RS_LO]),
		.read_b(read_b), .data_a(rf_a), .data_b(rf_b), .write_en(rf_write),
		.write_reg(memwb.rd), .write_data(wb_data));

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			idex_q.valid <= 1'b0;
			idex_q.ctrl <= '0;
		end else begin
			idex_q.valid <= ifid.valid & ~stall & ~redirect;
			idex_q.ctrl <= ctrl_dec;
		end
		idex_q.pc <= ifid.pc;
		idex_q.rd <= ifid.instr[RD_HI:RD_LO];
		idex_q.rs <= ifid.instr[RS_HI:RS_LO];
		idex_q.rt <= read_b;
		idex_q.rs_data <= rf_a;
		idex_q.rt_data <= rf_b;
		idex_q.imm <= imm_dec;
	end

	////////////////////
	// Execute
	assign op_a = fwd_mux(fwd_a, idex_q.rs_data, exmem_q.result, wb_data);
	assign op_b = fwd_mux(fwd_b, idex_q.rt_data, exmem_q.result, wb_data);
	assign alu_b = idex_q.ctrl.use_imm ? idex_q.imm : op_b;

	alu alu_unit (.op(idex_q.ctrl.alu_op), .cmp_kind(idex_q.ctrl.cmp_kind), .a(op_a),
		.b(alu_b), .result(alu_result), .take_branch(take_branch));

	assign branch_taken = idex_q.ctrl.branch & take_branch;
	assign redirect = branch_taken | idex_q.ctrl.jump;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			exmem_q.valid <= 1'b0;
			exmem_q.ctrl <= '0;
		end else begin
			exmem_q.valid <= idex_q.valid;
			exmem_q.ctrl <= idex_q.ctrl;
		end
		exmem_q.rd <= idex_q.rd;
		exmem_q.result <= alu_result;
		exmem_q.store_data <= op_b;
	end

	////////////////////
	// Memory and writeback
	data_mem dmem (.clock(clock), .addr(exmem_q.result[DMEM_ADDR_BITS-1:0]),
		.write_en(exmem_q.valid & exmem_q.ctrl.mem_write), .write_data(exmem_q.store_data),
		.read_data(dmem_rdata));

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			memwb_valid_q <= 1'b0;
			memwb_ctrl_q <= '0;
		end else begin
			memwb_valid_q <= exmem_q.valid;
			memwb_ctrl_q <= exmem_q.ctrl;
		end
		memwb_rd_q <= exmem_q.rd;
		memwb_alu_q <= exmem_q.result;
	end

	assign memwb = '{valid: memwb_valid_q, ctrl: memwb_ctrl_q, rd: memwb_rd_q,
		alu_result: memwb_alu_q, load_data: dmem_rdata};
	assign wb_data = memwb.ctrl.mem_read ? memwb.load_data : memwb.alu_result;
	assign rf_write = memwb.valid & memwb.ctrl.reg_write;

	// r0 writes are dropped, so they are not reported
	assign wb_valid = rf_write & (memwb.rd != '0);
	assign wb_event = '{rd: memwb.rd, data: wb_data};

endmodule

//--- tests/pipe_cpu_sva.sv
module pipe_cpu_sva (
	input logic                clock,
	input logic                rst_n,
	input logic                load_req,
	input logic                load_ack,
	input logic                wb_valid,
	input cpu_pkg::wb_event_t  wb_event,
	input logic                halted
);

	// Ack only answers a request seen on the previous clock
	ack_follows_req: assert property (@(posedge clock) disable iff (!rst_n)
		$rose(load_ack) |-> $past(load_req))
		else $error("load_ack rose without a pending load_req");

	// Sticky until the next reset
	halted_sticky: assert property (@(posedge clock) disable iff (!rst_n)
		halted |=> halted)
		else $error("halted fell without a reset");

	no_wb_after_halt: assert property (@(posedge clock) disable iff (!rst_n)
		halted |-> !wb_valid)
		else $error("writeback reported after halted");

	// r0 writes are never reported
	no_wb_to_r0: assert property (@(posedge clock) disable iff (!rst_n)
		wb_valid |-> wb_event.rd != '0)
		else $error("writeback event with rd equal to zero");

endmodule

bind pipe_cpu pipe_cpu_sva checks (.clock(clock), .rst_n(rst_n), .load_req(load_req),
	.load_ack(load_ack), .wb_valid(wb_valid), .wb_event(wb_event), .halted(halted));

//--- tests/pipe_cpu_tb.sv
module pipe_cpu_tb;
	import cpu_pkg::*;

	logic clock;
	logic rst_n;
	logic load_req;
	load_word_t load_word;
	logic load_ack;
	logic run;
	logic wb_valid;
	wb_event_t wb_event;
	logic halted;

	// Flat storage with case boundaries kept as end indices
	logic [XLEN-1:0] prog_words[$];
	logic [63:0] exp_events[$];
	int prog_end[$];
	int exp_end[$];
	logic cases_ready;
	logic [31:0] lcg_state;

	pipe_cpu DUT (
		.clock(clock),
		.rst_n(rst_n),
		.load_req(load_req),
		.load_word(load_word),
		.load_ack(load_ack),
		.run(run),
		.wb_valid(wb_valid),
		.wb_event(wb_event),
		.halted(halted)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#20 clock = ~clock;
		end
	end

	////////////////////
	// Helpers
	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	task automatic end_with_failure();
		$display("Test FAILED");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_equal(input logic [63:0] got, input logic [63:0] expected,
			input string what);
		if (got !== expected) begin
			$display("mismatch at time %0t: %s, got %h, expected %h", $time, what, got,
				expected);
			end_with_failure();
		end
	endtask

	// Drop the rest of the line including trailing notes
	task automatic skip_line(input int fd);
		int ch;
		ch = $fgetc(fd);
		while (ch != 10 && ch != -1) begin
			ch = $fgetc(fd);
		end
	endtask

	task automatic read_cases();
		int fd;
		int code;
		logic [7:0] kind;
		logic [31:0] field_a;
		logic [31:0] field_b;
		logic at_end;
		fd = $fopen("tests/pipe_cpu_cases.txt", "r");
		if (fd == 0) begin
			$display("could not open tests/pipe_cpu_cases.txt");
			end_with_failure();
		end
		at_end = 1'b0;
		while (!at_end) begin
			code = $fscanf(fd, " %c", kind);
			if (code != 1) begin
				at_end = 1'b1;
			end else begin
				case (kind)
					"#": code = 1;
					"P": begin
						code = $fscanf(fd, "%h", field_a);
						prog_words.push_back(field_a);
					end
					"W": begin
						code = $fscanf(fd, "%h %h", field_a, field_b) - 1;
						exp_events.push_back({27'd0, field_a[REG_BITS-1:0], field_b});
					end
					"E": begin
						prog_end.push_back(prog_words.size());
						exp_end.push_back(exp_events.size());
					end
					default: code = 0;
				endcase
				if (code != 1) begin
					$display("cases file has a malformed line starting with '%c'", kind);
					end_with_failure();
				end
				skip_line(fd);
			end
		end
		$fclose(fd);
		if (prog_end.size() == 0) begin
			$display("cases file holds no complete case");
			end_with_failure();
		end
	endtask

	////////////////////
	// Stimulus
	task automatic apply_reset();
		@(negedge clock);
		rst_n = 1'b0;
		run = 1'b0;
		load_req = 1'b0;
		load_word = '0;
		repeat (4) @(negedge clock);
		rst_n = 1'b1;
		check_equal(64'(halted), 64'd0, "halted after reset");
		check_equal(64'(load_ack), 64'd0, "load_ack after reset");
		check_equal(64'(wb_valid), 64'd0, "wb_valid after reset");
	endtask

	// Four-phase handshake with a random hold before req drops
	task automatic load_one_word(input int addr, input logic [XLEN-1:0] data);
		int hold;
		hold = int'((next_random() >> 16) % 32'd5);
		@(negedge clock);
		load_word.addr = addr[IMEM_ADDR_BITS-1:0];
		load_word.data = data;
		load_req = 1'b1;
		@(negedge clock);
		while (!load_ack) begin
			@(negedge clock);
		end
		repeat (hold) @(negedge clock);
		load_req = 1'b0;
		@(negedge clock);
		while (load_ack) begin
			@(negedge clock);
		end
	endtask

	task automatic run_case(input int first_exp, input int last_exp);
		int next_exp;
		next_exp = first_exp;
		@(negedge clock);
		run = 1'b1;
		while (!halted) begin
			@(negedge clock);
			if (wb_valid) begin
				if (next_exp >= last_exp) begin
					$display("unexpected writeback to r%0d at time %0t, none left to match",
						wb_event.rd, $time);
					end_with_failure();
				end
				check_equal(64'(wb_event), exp_events[next_exp], "writeback rd and data");
				next_exp++;
			end
		end
		check_equal(64'(last_exp - next_exp), 64'd0, "expected writebacks left at halt");
		// The pipeline drains quietly once halted
		repeat (4) begin
			@(negedge clock);
			check_equal(64'(wb_valid), 64'd0, "wb_valid after halted");
			check_equal(64'(halted), 64'd1, "halted held high");
		end
	endtask

	////////////////////
	initial begin
		int p_first;
		int e_first;
		rst_n = 1'b0;
		run = 1'b0;
		load_req = 1'b0;
		load_word = '0;
		cases_ready = 1'b0;
		lcg_state = 32'd46811;
		read_cases();
		cases_ready = 1'b1;
		p_first = 0;
		e_first = 0;
		for (int c = 0; c < prog_end.size(); c++) begin
			apply_reset();
			for (int i = p_first; i < prog_end[c]; i++) begin
				load_one_word(i - p_first, prog_words[i]);
			end
			run_case(e_first, exp_end[c]);
			$display("case %0d halted after %0d writebacks", c, exp_end[c] - e_first);
			p_first = prog_end[c];
			e_first = exp_end[c];
		end
		$display("Test OK");
		$finish;
	end

	// Budget of 200 cycles per program word and per expected writeback
	initial begin
		wait (cases_ready);
		repeat (200 * (prog_words.size() + exp_events.size())) @(posedge clock);
		$display("watchdog expired before all cases reached halted");
		end_with_failure();
	end

endmodule

//--- tests/pipe_cpu_cases.txt
# P word: instruction in hex, loaded from address 0 upward
# W rd data: next expected writeback in hex, E ends a case, text after the fields is a note
# ALU, forwarding, r0 write, branches, jump and halt
P 40400005 addi r1, r0, 5
P 40800003 addi r2, r0, 3
P 08C22000 add r3, r1, r2
P 11061000 sub r4, r3, r1
P 29462000 xor r5, r3, r2
P 318A2000 sll r6, r5, r2
P 400C0001 addi r0, r6, 1
P 58880001 beq r4, r2 taken to 9
P 41C00001 addi r7, r0, 1 skipped
P 41C1FFFE addi r7, r0, -2
P 680E0001 blt r7, r0 taken to 12
P 42000009 addi r8, r0, 9 skipped
P 58820001 beq r1, r2 not taken
P 22001000 or r8, r0, r1
P 70000010 jmp 16
P 42400001 addi r9, r0, 1 skipped
P 78000000 halt
P 42400002 addi r9, r0, 2 after halt
W 1 00000005
W 2 00000003
W 3 00000008
W 4 00000003
W 5 0000000b
W 6 00000058
W 7 fffffffe
W 8 00000005
E
# Store, load and load-use stalls
P 4040002A addi r1, r0, 0x2a
P 40800010 addi r2, r0, 0x10
P 50440004 sw r1, 4(r2)
P 48C40004 lw r3, 4(r2)
P 09061000 add r4, r3, r1 stalls on r3
P 49440004 lw r5, 4(r2)
P 11845000 sub r6, r2, r5 stalls on r5
P 78000000 halt
W 1 0000002a
W 2 00000010
W 3 0000002a
W 4 00000054
W 5 0000002a
W 6 ffffffe6
E

//--- pipe_cpu.f
design/cpu_pkg.sv
design/instr_mem.sv
design/reg_file.sv
design/alu.sv
design/data_mem.sv
design/pipeline_control.sv
design/pipe_cpu.sv
tests/pipe_cpu_sva.sv
tests/pipe_cpu_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and pass only if the testbench printed its pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module pipe_cpu_tb -f pipe_cpu.f \
	-o pipe_cpu_sim || { echo "build failed"; exit 1; }
out=$(./obj_dir/pipe_cpu_sim 2>&1)
echo "$out"
echo "$out" | grep -qx "Test OK" && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
